//--- hdl/uart_pkg.sv
/*
 * Shared constants for the four-channel serial port peripheral
 * Channel count, data widths and the register map of one channel
 */
package uart_pkg;

   // Number of serial channels behind the bus slave
   localparam int NUM_PORTS = 4;

   // Bit period in clock cycles, one divider per channel
   localparam int CLKDIV_W = 16;

   // FIFO fill level as seen by software, zero-extended
   localparam int LEVEL_W = 8;

   // One character on the line, 8N1 framing
   localparam int CHAR_W = 8;

   // Register offsets within a channel
   // Decoded from adr_i[2:0], adr_i[4:3] picks the channel
   localparam logic [2:0] REG_CLKDIV  = 3'd0;  // R/W divider
   localparam logic [2:0] REG_TXLEVEL = 3'd1;  // RO transmit fill level
   localparam logic [2:0] REG_RXLEVEL = 3'd2;  // RO receive fill level
   localparam logic [2:0] REG_TXCHAR  = 3'd3;  // WO push into transmit FIFO
   localparam logic [2:0] REG_RXCHAR  = 3'd4;  // RO pop from receive FIFO

   // Offsets 5 to 7 are unmapped and read back zero

endpackage

//--- hdl/char_fifo.sv
/*
 * Character FIFO
 * Circular buffer of 2**DEPTH_LOG entries with fill level count
 * Head entry is visible on rdata_o without a read strobe
 */
module char_fifo #(
   parameter int DEPTH_LOG = 2
) (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         wr_i,
   input  logic [uart_pkg::CHAR_W-1:0]  wdata_i,
   input  logic                         rd_i,
   output logic [uart_pkg::CHAR_W-1:0]  rdata_o,
   output logic [uart_pkg::LEVEL_W-1:0] level_o,
   output logic                         full_o,
   output logic                         empty_o
);
   import uart_pkg::*;

   localparam int DEPTH = 2 ** DEPTH_LOG;

   logic [CHAR_W-1:0]    mem [DEPTH];   // Storage, no reset needed
   logic [DEPTH_LOG-1:0] wr_ptr_q;      // Next slot to fill
   logic [DEPTH_LOG-1:0] rd_ptr_q;      // Current head
   logic [DEPTH_LOG:0]   count_q;       // 0 .. DEPTH entries
   logic                 do_wr;
   logic                 do_rd;

   // Qualified strobes, overflow and underflow are silently ignored
   assign do_wr = wr_i && !full_o;
   assign do_rd = rd_i && !empty_o;

   // Count reaches DEPTH only when the top bit is set
   assign full_o  = count_q[DEPTH_LOG];
   assign empty_o = (count_q == '0);
   assign level_o = LEVEL_W'(count_q);  // DEPTH_LOG <= 7 keeps it in range

   assign rdata_o = mem[rd_ptr_q];      // Show-ahead head

   always_ff @(posedge clk_i)
   begin
      if (do_wr)
         mem[wr_ptr_q] <= wdata_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at DEPTH
         if (do_rd)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;  // Both or neither, level unchanged
         endcase
      end
   end

endmodule

//--- hdl/uart_tx.sv
/*
 * Transmit channel
 * Character FIFO feeding an 8N1 serializer, LSB first
 * Bit-rate clock on baud_o, high in the first half of each bit
 */
module uart_tx #(
   parameter int DEPTH_LOG = 2
) (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          push_i,
   input  logic [uart_pkg::CHAR_W-1:0]   char_i,
   input  logic [uart_pkg::CLKDIV_W-1:0] clkdiv_i,
   output logic [uart_pkg::LEVEL_W-1:0]  level_o,
   output logic                          full_o,
   output logic                          tx_o,
   output logic                          baud_o
);
   import uart_pkg::*;

   logic                fifo_empty;
   logic [CHAR_W-1:0]   fifo_head;
   logic                fifo_pop;
   logic                enable;     // Divider of 2 or more
   logic                bit_end;    // Last cycle of current bit
   logic                frame_end;  // Last cycle of stop bit
   logic                busy_q;
   logic [CLKDIV_W-1:0] tick_q;     // Cycles spent in current bit
   logic [3:0]          bit_idx_q;  // 0 start, 1..8 data, 9 stop
   logic [CHAR_W+1:0]   frame_q;    // Stop, data, start; bit 0 on the line

   char_fifo #(
      .DEPTH_LOG(DEPTH_LOG)
   ) tx_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .wr_i    (push_i),
      .wdata_i (char_i),
      .rd_i    (fifo_pop),
      .rdata_o (fifo_head),
      .level_o (level_o),
      .full_o  (full_o),
      .empty_o (fifo_empty)
   );

   assign enable    = (clkdiv_i >= CLKDIV_W'(2));
   // >= also catches a divider lowered in the middle of a bit
   assign bit_end   = (tick_q >= clkdiv_i - CLKDIV_W'(1));
   assign frame_end = busy_q && bit_end && (bit_idx_q == 4'd9);

   // Take a character when idle, or back to back at the end of a frame
   assign fifo_pop = enable && !fifo_empty && (!busy_q || frame_end);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         busy_q    <= 1'b0;
         tick_q    <= '0;
         bit_idx_q <= '0;
      end
      else if (!enable)
      begin
         busy_q    <= 1'b0;  // Halted, abandon any frame in flight
         tick_q    <= '0;
         bit_idx_q <= '0;
      end
      else if (fifo_pop)
      begin
         busy_q    <= 1'b1;  // Start bit goes out next cycle
         tick_q    <= '0;
         bit_idx_q <= '0;
      end
      else if (frame_end)
         busy_q <= 1'b0;
      else if (busy_q)
      begin
         if (bit_end)
         begin
            tick_q    <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
         end
         else
            tick_q <= tick_q + 1'b1;
      end
   end

   // Frame shift register, only meaningful while busy
   always_ff @(posedge clk_i)
   begin
      if (fifo_pop)
         frame_q <= {1'b1, fifo_head, 1'b0};
      else if (busy_q && bit_end)
         frame_q <= {1'b1, frame_q[CHAR_W+1:1]};  // Shift in idle level
   end

   assign tx_o   = busy_q ? frame_q[0] : 1'b1;              // Line idles high
   assign baud_o = busy_q && (tick_q < (clkdiv_i >> 1));    // First half high

endmodule

//--- hdl/uart_rx.sv
/*
 * Receive channel
 * 8N1 deserializer, samples each bit at its middle
 * Characters with a valid stop bit go into a character FIFO
 */
module uart_rx #(
   parameter int DEPTH_LOG = 2
) (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          pop_i,
   input  logic [uart_pkg::CLKDIV_W-1:0] clkdiv_i,
   input  logic                          rx_i,
   output logic [uart_pkg::CHAR_W-1:0]   char_o,
   output logic [uart_pkg::LEVEL_W-1:0]  level_o,
   output logic                          empty_o
);
   import uart_pkg::*;

   logic                rx_meta_q;   // First synchronizer stage
   logic                rx_sync_q;   // Safe to use
   logic                rx_prev_q;   // For edge detection
   logic                enable;
   logic                start_edge;
   logic                sample;      // Middle of current bit
   logic                data_bit;    // Sample lands on a data bit
   logic                fifo_push;
   logic                busy_q;
   logic [CLKDIV_W-1:0] tick_q;      // Counts down to next sample point
   logic [3:0]          bit_idx_q;   // 0 start, 1..8 data, 9 stop
   logic [CHAR_W-1:0]   shift_q;     // Data bits, LSB arrives first

   char_fifo #(
      .DEPTH_LOG(DEPTH_LOG)
   ) rx_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .wr_i    (fifo_push),
      .wdata_i (shift_q),
      .rd_i    (pop_i),
      .rdata_o (char_o),
      .level_o (level_o),
      .full_o  (),                 // Overrun simply drops the character
      .empty_o (empty_o)
   );

   // Two-stage synchronizer, reset to the idle line level
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         rx_meta_q <= 1'b1;
         rx_sync_q <= 1'b1;
         rx_prev_q <= 1'b1;
      end
      else
      begin
         rx_meta_q <= rx_i;
         rx_sync_q <= rx_meta_q;
         rx_prev_q <= rx_sync_q;
      end
   end

   assign enable     = (clkdiv_i >= CLKDIV_W'(2));
   assign start_edge = rx_prev_q && !rx_sync_q;
   assign sample     = busy_q && (tick_q == '0);
   assign data_bit   = (bit_idx_q != 4'd0) && (bit_idx_q != 4'd9);
   assign fifo_push  = sample && (bit_idx_q == 4'd9) && rx_sync_q;  // Good stop bit

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         busy_q    <= 1'b0;
         tick_q    <= '0;
         bit_idx_q <= '0;
      end
      else if (!enable)
         busy_q <= 1'b0;  // Line ignored while halted
      else if (!busy_q)
      begin
         if (start_edge)
         begin
            busy_q    <= 1'b1;
            tick_q    <= (clkdiv_i >> 1) - CLKDIV_W'(1);  // Half a bit to mid start
            bit_idx_q <= '0;
         end
      end
      else if (sample)
      begin
         tick_q <= clkdiv_i - CLKDIV_W'(1);  // Whole bit to next middle
         if (bit_idx_q == 4'd0 && rx_sync_q)
            busy_q <= 1'b0;                  // Glitch, start bit not held
         else if (bit_idx_q == 4'd9)
            busy_q <= 1'b0;                  // Stop bit done, rearm for next edge
         else
            bit_idx_q <= bit_idx_q + 1'b1;
      end
      else
         tick_q <= tick_q - CLKDIV_W'(1);
   end

   // Payload shift register, MSB in so first bit ends at bit 0
   always_ff @(posedge clk_i)
   begin
      if (sample && data_bit)
         shift_q <= {rx_sync_q, shift_q[CHAR_W-1:1]};
   end

endmodule

//--- hdl/quad_uart.sv
/*
 * Four-channel serial port peripheral
 * Register bus slave with one-cycle ack, per-channel divider,
 * transmit and receive FIFOs, and space/data interrupt levels
 */
module quad_uart #(
   parameter int TX_DEPTH_LOG = 4,
   parameter int RX_DEPTH_LOG = 4
) (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           cyc_i,
   input  logic                           stb_i,
   input  logic                           we_i,
   input  logic [4:0]                     adr_i,
   input  logic [31:0]                    dat_i,
   output logic                           ack_o,
   output logic [31:0]                    dat_o,
   output logic [uart_pkg::NUM_PORTS-1:0] tx_int_o,
   output logic [uart_pkg::NUM_PORTS-1:0] rx_int_o,
   output logic [uart_pkg::NUM_PORTS-1:0] tx_o,
   input  logic [uart_pkg::NUM_PORTS-1:0] rx_i,
   output logic [uart_pkg::NUM_PORTS-1:0] baud_o
);
   import uart_pkg::*;

   logic                 acc;         // Bus access in progress
   logic                 acc_start;   // First cycle, before ack
   logic                 wr_ack;      // Write commits in ack cycle
   logic [1:0]           chan;        // Selected channel
   logic [2:0]           reg_off;     // Register within channel
   logic [CLKDIV_W-1:0]  clkdiv_q [NUM_PORTS];
   logic [NUM_PORTS-1:0] tx_push;
   logic [NUM_PORTS-1:0] rx_pop_q;    // High in ack cycle of an RXCHAR read
   logic [NUM_PORTS-1:0] tx_full;
   logic [NUM_PORTS-1:0] rx_empty;
   logic [LEVEL_W-1:0]   tx_level [NUM_PORTS];
   logic [LEVEL_W-1:0]   rx_level [NUM_PORTS];
   logic [CHAR_W-1:0]    rx_char  [NUM_PORTS];

   assign acc       = cyc_i && stb_i;
   assign acc_start = acc && !ack_o;
   assign wr_ack    = ack_o && acc && we_i;  // Master holds inputs until ack
   assign chan      = adr_i[4:3];
   assign reg_off   = adr_i[2:0];

   // Single pulse per access, low again before the next one
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         ack_o <= 1'b0;
      else
         ack_o <= acc_start;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         for (int i = 0; i < NUM_PORTS; i++)
            clkdiv_q[i] <= '0;  // All transmitters halted
      end
      else if (wr_ack && reg_off == REG_CLKDIV)
         clkdiv_q[chan] <= dat_i[CLKDIV_W-1:0];
   end

   // Read data captured in the cycle before ack, held through ack
   always_ff @(posedge clk_i)
   begin
      if (acc_start)
      begin
         case (reg_off)
            REG_CLKDIV:  dat_o <= 32'(clkdiv_q[chan]);
            REG_TXLEVEL: dat_o <= 32'(tx_level[chan]);
            REG_RXLEVEL: dat_o <= 32'(rx_level[chan]);
            REG_RXCHAR:  dat_o <= rx_empty[chan] ? '0 : 32'(rx_char[chan]);
            default:     dat_o <= '0;  // Unmapped and write-only offsets
         endcase
      end
   end

   // Pop decision taken with the read data, so a character that lands
   // between capture and ack is not lost
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         rx_pop_q <= '0;
      else
      begin
         rx_pop_q <= '0;
         if (acc_start && !we_i && reg_off == REG_RXCHAR && !rx_empty[chan])
            rx_pop_q[chan] <= 1'b1;
      end
   end

   for (genvar k = 0; k < NUM_PORTS; k++)
   begin : gen_chan
      assign tx_push[k] = wr_ack && (reg_off == REG_TXCHAR) && (chan == 2'(k));

      uart_tx #(
         .DEPTH_LOG(TX_DEPTH_LOG)
      ) u_tx (
         .clk_i    (clk_i),
         .rst_i    (rst_i),
         .push_i   (tx_push[k]),
         .char_i   (dat_i[CHAR_W-1:0]),
         .clkdiv_i (clkdiv_q[k]),
         .level_o  (tx_level[k]),
         .full_o   (tx_full[k]),
         .tx_o     (tx_o[k]),
         .baud_o   (baud_o[k])
      );

      uart_rx #(
         .DEPTH_LOG(RX_DEPTH_LOG)
      ) u_rx (
         .clk_i    (clk_i),
         .rst_i    (rst_i),
         .pop_i    (rx_pop_q[k]),
         .clkdiv_i (clkdiv_q[k]),
         .rx_i     (rx_i[k]),
         .char_o   (rx_char[k]),
         .level_o  (rx_level[k]),
         .empty_o  (rx_empty[k])
      );
   end

   assign tx_int_o = ~tx_full;   // Room for another character
   assign rx_int_o = ~rx_empty;  // Character waiting

endmodule

//--- sim/tb_quad_uart.sv
/*
 * Testbench for the four-channel serial port peripheral
 * Table of bus operations applied in a loop, every tx line looped to its rx
 */
module tb_quad_uart;
   import uart_pkg::*;

   // Table operations
   localparam int OP_WR     = 0;  // Bus write
   localparam int OP_RD     = 1;  // Bus read, compare with expected
   localparam int OP_WAIT   = 2;  // Poll a register until it matches
   localparam int OP_PINS   = 3;  // Compare {tx_int, rx_int}
   localparam int OP_SETTLE = 4;  // Idle for data cycles
   localparam int MARGIN    = 500;

   logic                 clk = 1'b0;
   logic                 rst;
   logic                 cyc;
   logic                 stb;
   logic                 we;
   logic [4:0]           adr;
   logic [31:0]          wdat;
   logic                 ack;
   logic [31:0]          rdat;
   logic [NUM_PORTS-1:0] tx_int;
   logic [NUM_PORTS-1:0] rx_int;
   logic [NUM_PORTS-1:0] tx_line;  // Also feeds rx_i, loopback
   logic [NUM_PORTS-1:0] baud;

   integer seed        = 32'h512d_58dd;
   int     cycle_count = 0;
   int     cycle_limit = 100000;  // Replaced once the table is built

   // Stimulus table, one entry per row in each queue
   int          op_q   [$];
   logic [1:0]  chan_q [$];
   logic [2:0]  off_q  [$];
   logic [31:0] data_q [$];
   logic [31:0] exp_q  [$];
   string       name_q [$];
   string       test_name;

   // Characters expected per channel, in send order
   logic [7:0] model_mem [NUM_PORTS][64];
   logic [5:0] model_wr  [NUM_PORTS];
   logic [5:0] model_rd  [NUM_PORTS];
   int         div_model [NUM_PORTS];
   int         max_div = 2;

   // Bit-rate clock tracking while the table runs
   int                   cur_div   [NUM_PORTS];  // Divider in force on each channel
   int                   high_len  [NUM_PORTS];  // Cycles baud has been high so far
   logic [NUM_PORTS-1:0] line_prev = '1;

   quad_uart #(
      .TX_DEPTH_LOG(2),
      .RX_DEPTH_LOG(2)
   ) UUT (
      .clk_i    (clk),
      .rst_i    (rst),
      .cyc_i    (cyc),
      .stb_i    (stb),
      .we_i     (we),
      .adr_i    (adr),
      .dat_i    (wdat),
      .ack_o    (ack),
      .dat_o    (rdat),
      .tx_int_o (tx_int),
      .rx_int_o (rx_int),
      .tx_o     (tx_line),
      .rx_i     (tx_line),
      .baud_o   (baud)
   );

   always #20 clk = ~clk;

   // Run length guard
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout: the table did not finish within %0d clock cycles", cycle_limit);
         $display("TEST FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // Bit-rate clock monitor, DUT outputs only move on rising edges
   always @(negedge clk)
   begin
      if (!rst)
      begin
         for (int k = 0; k < NUM_PORTS; k++)
         begin
            // Line changes only at a bit start, where baud is high
            if (tx_line[k] != line_prev[k])
               compare_value("baud high at bit start", 32'd1, 32'(baud[k]));
            if (baud[k])
               high_len[k] = high_len[k] + 1;
            else if (high_len[k] != 0)
            begin
               compare_value("baud high time", 32'(cur_div[k] / 2), 32'(high_len[k]));
               high_len[k] = 0;
            end
            line_prev[k] = tx_line[k];
         end
      end
   end

   // One access, called on a falling edge, returns on a falling edge
   task automatic bus_access(input logic write, input logic [4:0] addr,
                             input logic [31:0] data, output logic [31:0] result);
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = write;
      adr  = addr;
      wdat = data;
      @(negedge clk);
      while (!ack)
         @(negedge clk);
      result = rdat;   // Valid in the ack cycle
      @(negedge clk);  // Hold through the edge that commits the access
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic add_row(input int op, input logic [1:0] chan, input logic [2:0] off,
                          input logic [31:0] data, input logic [31:0] expected);
      op_q.push_back(op);
      chan_q.push_back(chan);
      off_q.push_back(off);
      data_q.push_back(data);
      exp_q.push_back(expected);
      name_q.push_back(test_name);
   endtask

   task automatic set_divider(input logic [1:0] chan, input int value);
      add_row(OP_WR, chan, REG_CLKDIV, 32'(value), '0);
      div_model[chan] = value;
      if (value > max_div)
         max_div = value;
   endtask

   // Random character into the TX FIFO, kept in the model unless it will be lost
   task automatic send_char(input logic [1:0] chan, input bit keep);
      logic [31:0] rnd;
      rnd = $random(seed);
      add_row(OP_WR, chan, REG_TXCHAR, {24'h0, rnd[7:0]}, '0);
      if (keep)
      begin
         model_mem[chan][model_wr[chan]] = rnd[7:0];
         model_wr[chan] = model_wr[chan] + 6'd1;
      end
   endtask

   task automatic expect_char(input logic [1:0] chan);
      add_row(OP_RD, chan, REG_RXCHAR, '0, {24'h0, model_mem[chan][model_rd[chan]]});
      model_rd[chan] = model_rd[chan] + 6'd1;
   endtask

   task automatic build_table();
      model_wr = '{default: '0};
      model_rd = '{default: '0};
      test_name = "reset state";
      for (int k = 0; k < NUM_PORTS; k++)
      begin
         add_row(OP_RD, 2'(k), REG_TXLEVEL, '0, '0);
         add_row(OP_RD, 2'(k), REG_RXLEVEL, '0, '0);
      end
      add_row(OP_PINS, 2'd0, 3'd0, '0, 32'h0000_00f0);  // All space, no data
      test_name = "divider readback";
      for (int k = 0; k < NUM_PORTS; k++)
         set_divider(2'(k), 4 + k);
      for (int k = 0; k < NUM_PORTS; k++)
         add_row(OP_RD, 2'(k), REG_CLKDIV, '0, 32'(4 + k));
      add_row(OP_RD, 2'd2, 3'd5, '0, '0);  // Unmapped offsets
      add_row(OP_RD, 2'd3, 3'd7, '0, '0);
      test_name = "tx fifo full";
      set_divider(2'd0, 0);                // Halted, FIFO only fills
      for (int i = 0; i < 4; i++)
         send_char(2'd0, 1'b1);
      send_char(2'd0, 1'b0);               // Dropped at the full FIFO
      add_row(OP_RD, 2'd0, REG_TXLEVEL, '0, 32'd4);
      add_row(OP_PINS, 2'd0, 3'd0, '0, 32'h0000_00e0);
      test_name = "loopback";
      set_divider(2'd0, 4);
      add_row(OP_WAIT, 2'd0, REG_RXLEVEL, '0, 32'd4);
      add_row(OP_PINS, 2'd0, 3'd0, '0, 32'h0000_00f1);
      for (int i = 0; i < 4; i++)
      begin
         expect_char(2'd0);
         add_row(OP_RD, 2'd0, REG_RXLEVEL, '0, 32'(3 - i));
      end
      test_name = "four channels at once";
      for (int i = 0; i < 3; i++)
         for (int k = 0; k < NUM_PORTS; k++)
            send_char(2'(k), 1'b1);
      for (int k = 0; k < NUM_PORTS; k++)
         add_row(OP_WAIT, 2'(k), REG_RXLEVEL, '0, 32'd3);
      for (int k = 0; k < NUM_PORTS; k++)
         for (int i = 0; i < 3; i++)
            expect_char(2'(k));
      add_row(OP_PINS, 2'd0, 3'd0, '0, 32'h0000_00f0);
      test_name = "rx overrun";
      for (int i = 0; i < 6; i++)
         send_char(2'd1, i < 4);          // Only four fit the RX FIFO
      add_row(OP_WAIT, 2'd1, REG_TXLEVEL, '0, '0);
      add_row(OP_SETTLE, 2'd1, 3'd0, 32'(12 * div_model[1]), '0);  // Last frame lands
      add_row(OP_RD, 2'd1, REG_RXLEVEL, '0, 32'd4);
      for (int i = 0; i < 4; i++)
         expect_char(2'd1);
      add_row(OP_RD, 2'd1, REG_RXCHAR, '0, '0);  // Empty reads zero
      add_row(OP_RD, 2'd1, REG_RXLEVEL, '0, '0);
   endtask

   initial
   begin
      logic [31:0] rd;
      logic [4:0]  addr;
      rst  = 1'b1;
      cyc  = 1'b0;
      stb  = 1'b0;
      we   = 1'b0;
      adr  = '0;
      wdat = '0;
      build_table();
      cycle_limit = op_q.size() * 12 * max_div + MARGIN;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      compare_value("reset tx lines", 32'h0000_000f, {28'h0, tx_line});
      compare_value("reset baud", '0, {28'h0, baud});
      for (int r = 0; r < op_q.size(); r++)
      begin
         addr = {chan_q[r], off_q[r]};  // Channel in bits 4..3
         case (op_q[r])
            OP_WR:
            begin
               bus_access(1'b1, addr, data_q[r], rd);
               if (off_q[r] == REG_CLKDIV)
                  cur_div[chan_q[r]] = int'(data_q[r][CLKDIV_W-1:0]);
            end
            OP_RD:
            begin
               bus_access(1'b0, addr, '0, rd);
               compare_value(name_q[r], exp_q[r], rd);
            end
            OP_WAIT:
            begin
               bus_access(1'b0, addr, '0, rd);
               while (rd != exp_q[r])
                  bus_access(1'b0, addr, '0, rd);
            end
            OP_PINS:
               compare_value(name_q[r], exp_q[r], {24'h0, tx_int, rx_int});
            OP_SETTLE:
               repeat (data_q[r]) @(negedge clk);
            default:
               rd = '0;
         endcase
      end
      compare_value("idle baud", '0, {28'h0, baud});  // All transmitters back to idle
      $display("TEST OK");
      $finish;
   end

endmodule

//--- sources.f
hdl/uart_pkg.sv
hdl/char_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/quad_uart.sv
sim/tb_quad_uart.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the quad UART testbench with Verilator and run it
# Exit status is zero only when the pass message is printed

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 \
      --top-module tb_quad_uart \
      -f sources.f \
      --Mdir obj_dir \
      -o tb_quad_uart_sim; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/tb_quad_uart_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST OK" <<< "$output"; then
   exit 0
else
   echo "Pass message not found in simulation output"
   exit 1
fi
